//--- src/soc_pkg.sv
// SoC package with the bus word types, the target address map and controller width
package soc_pkg;

	// Bus byte address
	typedef logic [15:0] addr_t;

	// Bus data word, always accessed whole
	typedef logic [31:0] data_t;

	// Scratch RAM, RAM_WORDS words from this base
	localparam addr_t RAM_BASE = 16'h0000;

	// Configuration block, 4 words
	localparam addr_t CFG_BASE = 16'h0400;

	// Free-running system counter, 1 word
	localparam addr_t CNT_BASE = 16'h0500;

	// Game controller state, 1 word
	localparam addr_t PAD_BASE = 16'h0600;

	// Buttons per serial controller
	localparam int PAD_BITS = 8;

endpackage

//--- src/bus_fabric.sv
// Bus fabric: round-robin arbitration of two masters, address decode and read data return
`timescale 1ns/10ps
module bus_fabric #(
	parameter int RAM_WORDS = 256
) (
	input  logic                              clk_50mhz,
	input  logic                              resetn,
	input  logic                              m0_req,
	input  logic                              m0_we,
	input  soc_pkg::addr_t                    m0_addr,
	input  soc_pkg::data_t                    m0_wdata,
	output logic                              m0_ack,
	output soc_pkg::data_t                    m0_rdata,
	output logic                              m0_err,
	input  logic                              m1_req,
	input  logic                              m1_we,
	input  soc_pkg::addr_t                    m1_addr,
	input  soc_pkg::data_t                    m1_wdata,
	output logic                              m1_ack,
	output soc_pkg::data_t                    m1_rdata,
	output logic                              m1_err,
	output logic                              ram_sel,
	output logic                              cfg_sel,
	output logic                              cnt_sel,
	output logic                              pad_sel,
	output logic                              t_we,
	output logic [$bits(soc_pkg::addr_t)-3:0] t_addr,
	output soc_pkg::data_t                    t_wdata,
	input  soc_pkg::data_t                    ram_rdata,
	input  soc_pkg::data_t                    cfg_rdata,
	input  soc_pkg::data_t                    cnt_rdata,
	input  soc_pkg::data_t                    pad_rdata
);

	localparam logic [1:0] S_IDLE     = 2'd0;
	localparam logic [1:0] S_ACCESS   = 2'd1;
	localparam logic [1:0] S_ACK_WAIT = 2'd2;
	localparam logic [1:0] S_RELEASE  = 2'd3;

	logic [1:0]     state;
	logic           gnt;
	logic           prio;
	logic           pick;
	logic           g_req;
	logic           g_we;
	soc_pkg::addr_t g_addr;
	soc_pkg::addr_t base;
	soc_pkg::addr_t off;
	logic [3:0]     hit;
	soc_pkg::data_t t_rdata;

	function automatic logic in_window(soc_pkg::addr_t a, soc_pkg::addr_t b,
		int unsigned words);
		soc_pkg::addr_t d;
		d = a - b;
		return 32'(d) < words * 4;
	endfunction

	// Request fields of the granted master
	assign g_req   = gnt ? m1_req : m0_req;
	assign g_we    = gnt ? m1_we : m0_we;
	assign g_addr  = gnt ? m1_addr : m0_addr;
	assign t_we    = g_we;
	assign t_wdata = gnt ? m1_wdata : m0_wdata;

	// m1 wins a tie only when it holds priority
	assign pick = m1_req && (!m0_req || prio);

	assign hit[0] = in_window(g_addr, soc_pkg::RAM_BASE, RAM_WORDS);
	assign hit[1] = in_window(g_addr, soc_pkg::CFG_BASE, 4);
	assign hit[2] = in_window(g_addr, soc_pkg::CNT_BASE, 1);
	assign hit[3] = in_window(g_addr, soc_pkg::PAD_BASE, 1);

	always_comb begin
		base = soc_pkg::RAM_BASE;
		if (hit[1])
			base = soc_pkg::CFG_BASE;
		if (hit[2])
			base = soc_pkg::CNT_BASE;
		if (hit[3])
			base = soc_pkg::PAD_BASE;
	end

	assign off    = g_addr - base;
	assign t_addr = off[$bits(soc_pkg::addr_t)-1:2];

	// One select for the single access cycle, none when unmapped
	assign {pad_sel, cnt_sel, cfg_sel, ram_sel} = (state == S_ACCESS) ? hit : 4'b0000;

	// Unmapped leaves every term zero
	assign t_rdata = ({32{hit[0]}} & ram_rdata) | ({32{hit[1]}} & cfg_rdata) |
		({32{hit[2]}} & cnt_rdata) | ({32{hit[3]}} & pad_rdata);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state  <= S_IDLE;
			gnt    <= 1'b0;
			prio   <= 1'b0;
			m0_ack <= 1'b0;
			m1_ack <= 1'b0;
			m0_err <= 1'b0;
			m1_err <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (m0_req || m1_req) begin
						gnt   <= pick;
						prio  <= ~pick;
						state <= S_ACCESS;
					end
				end
				S_ACCESS: begin
					state <= S_ACK_WAIT;
				end
				S_ACK_WAIT: begin
					if (gnt) begin
						m1_ack <= 1'b1;
						m1_err <= ~|hit;
					end else begin
						m0_ack <= 1'b1;
						m0_err <= ~|hit;
					end
					state <= S_RELEASE;
				end
				default: begin
					// Hold ack and grant while the master keeps req up
					if (!g_req) begin
						m0_ack <= 1'b0;
						m1_ack <= 1'b0;
						m0_err <= 1'b0;
						m1_err <= 1'b0;
						state  <= S_IDLE;
					end
				end
			endcase
		end
	end

	// Writes return zero
	always_ff @(posedge clk_50mhz) begin
		if (state == S_ACK_WAIT) begin
			if (gnt)
				m1_rdata <= g_we ? '0 : t_rdata;
			else
				m0_rdata <= g_we ? '0 : t_rdata;
		end
	end

endmodule

//--- src/scratch_ram.sv
// Scratch RAM target: word-wide synchronous memory with one-cycle read
`timescale 1ns/10ps
module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic                         clk_50mhz,
	input  logic                         sel,
	input  logic                         we,
	input  logic [$clog2(RAM_WORDS)-1:0] addr,
	input  soc_pkg::data_t               wdata,
	output soc_pkg::data_t               rdata
);

	soc_pkg::data_t mem [RAM_WORDS];

	always_ff @(posedge clk_50mhz) begin
		if (sel) begin
			if (we)
				mem[addr] <= wdata;
			// Old contents on a write
			rdata <= mem[addr];
		end
	end

endmodule

//--- src/config_regs.sv
// Configuration register target: four words, word 0 bit 0 drives video rotation
`timescale 1ns/10ps
module config_regs (
	input  logic           clk_50mhz,
	input  logic           resetn,
	input  logic           sel,
	input  logic           we,
	input  logic [1:0]     addr,
	input  soc_pkg::data_t wdata,
	output soc_pkg::data_t rdata,
	output logic           rotate_video
);

	soc_pkg::data_t regs [4];

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			regs <= '{default: '0};
		else if (sel && we)
			regs[addr] <= wdata;
	end

	always_ff @(posedge clk_50mhz) begin
		if (sel)
			rdata <= regs[addr];
	end

	assign rotate_video = regs[0][0];

endmodule

//--- src/system_counter.sv
// System counter target: free-running cycle count, read only
`timescale 1ns/10ps
module system_counter (
	input  logic           clk_50mhz,
	input  logic           resetn,
	input  logic           sel,
	output soc_pkg::data_t rdata
);

	soc_pkg::data_t count;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	// Snapshot of the count at select
	always_ff @(posedge clk_50mhz) begin
		if (sel)
			rdata <= count;
	end

endmodule

//--- src/gamepad_reader.sv
// Game controller reader: polls two serial pads and exposes their button state
`timescale 1ns/10ps
module gamepad_reader #(
	parameter int POLL_DIV = 64
) (
	input  logic           clk_50mhz,
	input  logic           resetn,
	input  logic           sel,
	output soc_pkg::data_t rdata,
	input  logic [1:0]     pad_data,
	output logic           pad_clk,
	output logic           pad_latch
);

	localparam int DIV_W      = (POLL_DIV > 1) ? $clog2(POLL_DIV) : 1;
	localparam int LAST_PHASE = 2 * soc_pkg::PAD_BITS + 1;
	localparam int PH_W       = $clog2(LAST_PHASE + 1);

	logic [DIV_W-1:0]            div;
	logic                        tick;
	logic [PH_W-1:0]             phase;
	logic [PH_W-1:0]             phase_next;
	logic                        rise;
	logic [soc_pkg::PAD_BITS-1:0] sh [2];
	logic [soc_pkg::PAD_BITS-1:0] btn [2];
	logic                        valid;

	assign tick = (div == DIV_W'(POLL_DIV - 1));

	// Phase 0 latch, odd phases clock high, even phases clock low, last phase idle
	assign phase_next = (phase == PH_W'(LAST_PHASE)) ? '0 : phase + 1'b1;
	assign rise       = phase_next[0] && (phase_next != PH_W'(LAST_PHASE));

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div       <= '0;
			phase     <= PH_W'(LAST_PHASE);
			pad_clk   <= 1'b0;
			pad_latch <= 1'b0;
			valid     <= 1'b0;
		end else begin
			div <= tick ? '0 : div + 1'b1;
			if (tick) begin
				phase     <= phase_next;
				pad_latch <= (phase_next == '0);
				pad_clk   <= rise;
				if (phase_next == PH_W'(LAST_PHASE))
					valid <= 1'b1;
			end
		end
	end

	// Pads are active low, first bit lands in bit 0
	always_ff @(posedge clk_50mhz) begin
		if (tick) begin
			for (int i = 0; i < 2; i++) begin
				if (rise)
					sh[i] <= {~pad_data[i], sh[i][soc_pkg::PAD_BITS-1:1]};
				if (phase_next == PH_W'(LAST_PHASE))
					btn[i] <= sh[i];
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (sel)
			rdata <= soc_pkg::data_t'({valid, btn[1], btn[0]});
	end

endmodule

//--- src/soc_top.sv
// SoC top: two bus masters, the fabric and its four targets
`timescale 1ns/10ps
module soc_top #(
	parameter int RAM_WORDS = 256,
	parameter int POLL_DIV  = 64
) (
	input  logic           clk_50mhz,
	input  logic           resetn,
	input  logic           m0_req,
	input  logic           m0_we,
	input  soc_pkg::addr_t m0_addr,
	input  soc_pkg::data_t m0_wdata,
	output logic           m0_ack,
	output logic           m0_err,
	output soc_pkg::data_t m0_rdata,
	input  logic           m1_req,
	input  logic           m1_we,
	input  soc_pkg::addr_t m1_addr,
	input  soc_pkg::data_t m1_wdata,
	output logic           m1_ack,
	output logic           m1_err,
	output soc_pkg::data_t m1_rdata,
	input  logic [1:0]     pad_data,
	output logic           pad_clk,
	output logic           pad_latch,
	output logic           rotate_video
);

	localparam int RAM_AW = $clog2(RAM_WORDS);

	logic                              ram_sel;
	logic                              cfg_sel;
	logic                              cnt_sel;
	logic                              pad_sel;
	logic                              t_we;
	logic [$bits(soc_pkg::addr_t)-3:0] t_addr;
	soc_pkg::data_t                    t_wdata;
	soc_pkg::data_t                    ram_rdata;
	soc_pkg::data_t                    cfg_rdata;
	soc_pkg::data_t                    cnt_rdata;
	soc_pkg::data_t                    pad_rdata;

	bus_fabric #(
		.RAM_WORDS(RAM_WORDS)
	) fabric_i (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.m0_req(m0_req),
		.m0_we(m0_we),
		.m0_addr(m0_addr),
		.m0_wdata(m0_wdata),
		.m0_ack(m0_ack),
		.m0_rdata(m0_rdata),
		.m0_err(m0_err),
		.m1_req(m1_req),
		.m1_we(m1_we),
		.m1_addr(m1_addr),
		.m1_wdata(m1_wdata),
		.m1_ack(m1_ack),
		.m1_rdata(m1_rdata),
		.m1_err(m1_err),
		.ram_sel(ram_sel),
		.cfg_sel(cfg_sel),
		.cnt_sel(cnt_sel),
		.pad_sel(pad_sel),
		.t_we(t_we),
		.t_addr(t_addr),
		.t_wdata(t_wdata),
		.ram_rdata(ram_rdata),
		.cfg_rdata(cfg_rdata),
		.cnt_rdata(cnt_rdata),
		.pad_rdata(pad_rdata)
	);

	scratch_ram #(
		.RAM_WORDS(RAM_WORDS)
	) ram_i (
		.clk_50mhz(clk_50mhz),
		.sel(ram_sel),
		.we(t_we),
		.addr(t_addr[RAM_AW-1:0]),
		.wdata(t_wdata),
		.rdata(ram_rdata)
	);

	config_regs cfg_i (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.sel(cfg_sel),
		.we(t_we),
		.addr(t_addr[1:0]),
		.wdata(t_wdata),
		.rdata(cfg_rdata),
		.rotate_video(rotate_video)
	);

	system_counter cnt_i (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.sel(cnt_sel),
		.rdata(cnt_rdata)
	);

	gamepad_reader #(
		.POLL_DIV(POLL_DIV)
	) pad_i (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.sel(pad_sel),
		.rdata(pad_rdata),
		.pad_data(pad_data),
		.pad_clk(pad_clk),
		.pad_latch(pad_latch)
	);

endmodule

//--- testbench/soc_sva.sv
// Handshake and target select assertions for the bus fabric
`timescale 1ns/10ps
module soc_sva (
	input logic clk_50mhz,
	input logic resetn,
	input logic m0_req,
	input logic m0_ack,
	input logic m1_req,
	input logic m1_ack,
	input logic ram_sel,
	input logic cfg_sel,
	input logic cnt_sel,
	input logic pad_sel
);

	m0_ack_needs_req: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$rose(m0_ack) |-> m0_req)
		else $error("m0_ack rose while m0_req was low");

	m1_ack_needs_req: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$rose(m1_ack) |-> m1_req)
		else $error("m1_ack rose while m1_req was low");

	// Held through back-pressure
	m0_ack_holds: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		(m0_ack && m0_req) |=> m0_ack)
		else $error("m0_ack fell while m0_req was still high");

	m1_ack_holds: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		(m1_ack && m1_req) |=> m1_ack)
		else $error("m1_ack fell while m1_req was still high");

	one_target: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$onehot0({ram_sel, cfg_sel, cnt_sel, pad_sel}))
		else $error("more than one target select high");

endmodule

bind bus_fabric soc_sva sva_i (.*);

//--- testbench/soc_checker.sv
// Response checker that compares every master ack with the expected values of its test
`timescale 1ns/10ps
module soc_checker (
	input  logic             clk_50mhz,
	input  logic             m0_ack,
	input  soc_pkg::data_t   m0_rdata,
	input  logic             m0_err,
	input  logic             m1_ack,
	input  soc_pkg::data_t   m1_rdata,
	input  logic             m1_err,
	input  logic             rotate_video,
	input  logic [1:0][31:0] exp_rdata,
	input  logic [1:0]       exp_err,
	input  logic [1:0]       exp_rot,
	input  logic [1:0]       exp_cnt,
	input  logic [1:0][7:0]  test_id,
	input  logic             pair_on,
	input  logic             exp_first,
	output int               checked,
	output int               failed
);

	logic [1:0]     ack_q = 2'b00;
	logic           first_seen = 1'b0;
	logic           cnt_seen = 1'b0;
	soc_pkg::data_t cnt_prev = '0;
	int unsigned    cnt_cycle = 0;
	int unsigned    cycle = 0;
	int             n_checked = 0;
	int             n_failed = 0;

	assign checked = n_checked;
	assign failed = n_failed;

	always @(posedge clk_50mhz) begin
		logic [1:0]     ack_v;
		logic [1:0]     err_v;
		soc_pkg::data_t rd_v [2];
		soc_pkg::data_t min_v;
		int             bad;
		ack_v = {m1_ack, m0_ack};
		err_v = {m1_err, m0_err};
		rd_v[0] = m0_rdata;
		rd_v[1] = m1_rdata;
		if (!pair_on)
			first_seen = 1'b0;
		for (int m = 0; m < 2; m++) begin
			if (ack_v[m] && !ack_q[m]) begin
				bad = 0;
				if (exp_cnt[m]) begin
					// Counter gains at least one per cycle between two reads
					if (cnt_seen) begin
						min_v = cnt_prev + (cycle - cnt_cycle);
						if (rd_v[m] < min_v) begin
							$display("Error: test %0d m%0d_rdata = 0x%08h, minimum 0x%08h",
								test_id[m], m, rd_v[m], min_v);
							bad++;
						end
					end
					cnt_seen = 1'b1;
					cnt_prev = rd_v[m];
					cnt_cycle = cycle;
				end else if (rd_v[m] !== exp_rdata[m]) begin
					$display("Error: test %0d m%0d_rdata = 0x%08h, expected 0x%08h",
						test_id[m], m, rd_v[m], exp_rdata[m]);
					bad++;
				end
				if (err_v[m] !== exp_err[m]) begin
					$display("Error: test %0d m%0d_err = 0x%0h, expected 0x%0h",
						test_id[m], m, err_v[m], exp_err[m]);
					bad++;
				end
				if (rotate_video !== exp_rot[m]) begin
					$display("Error: test %0d rotate_video = 0x%0h, expected 0x%0h",
						test_id[m], rotate_video, exp_rot[m]);
					bad++;
				end
				if (pair_on) begin
					// Second ack of a pair closes it
					if (first_seen) begin
						first_seen = 1'b0;
					end else begin
						first_seen = 1'b1;
						if (m != int'(exp_first)) begin
							$display("Test %0d: m%0d got the first grant, expected m%0d",
								test_id[m], m, exp_first);
							bad++;
						end
					end
				end
				n_checked++;
				if (bad != 0)
					n_failed++;
				else
					$display("Test %0d on m%0d passed", test_id[m], m);
			end
		end
		ack_q = ack_v;
		cycle++;
	end

endmodule

//--- testbench/soc_tb.sv
// Testbench for the SoC bus: clock, reset, master drivers, controller models and test table
`timescale 1ns/10ps
module soc_tb;

	localparam int N_TESTS = 29;
	localparam int LIMIT = N_TESTS * 40 + 2000;
	localparam logic [7:0] PAD0_BUTTONS = 8'ha5;
	localparam logic [7:0] PAD1_BUTTONS = 8'h3c;
	// Valid flag above controller 1 above controller 0
	localparam logic [31:0] PAD_WORD = {15'd0, 1'b1, PAD1_BUTTONS, PAD0_BUTTONS};

	typedef struct packed {
		logic           master;
		logic           we;
		soc_pkg::addr_t addr;
		soc_pkg::data_t wdata;
		soc_pkg::data_t rdata;
		logic           err;
		logic           rot;
		logic           cnt;
		logic           pair;
	} entry_t;

	entry_t           tbl [N_TESTS];
	logic             clk_50mhz;
	logic             resetn;
	logic [1:0]       req;
	logic [1:0]       we;
	soc_pkg::addr_t   addr [2];
	soc_pkg::data_t   wdata [2];
	logic             m0_ack;
	logic             m0_err;
	soc_pkg::data_t   m0_rdata;
	logic             m1_ack;
	logic             m1_err;
	soc_pkg::data_t   m1_rdata;
	logic [1:0]       ack;
	wire [1:0]        pad_data;
	logic             pad_clk;
	logic             pad_latch;
	logic             rotate_video;
	logic [1:0][31:0] exp_rdata;
	logic [1:0]       exp_err;
	logic [1:0]       exp_rot;
	logic [1:0]       exp_cnt;
	logic [1:0][7:0]  test_id;
	logic             pair_on;
	logic             exp_first;
	logic             last_m;
	int               checked;
	int               failed;
	int               cycles = 0;
	int               latch_count = 0;
	int               cur_test = -1;
	int               i;

	assign ack = {m1_ack, m0_ack};

	soc_top #(
		.POLL_DIV(4)
	) dut_i (
		.m0_req(req[0]),
		.m0_we(we[0]),
		.m0_addr(addr[0]),
		.m0_wdata(wdata[0]),
		.m1_req(req[1]),
		.m1_we(we[1]),
		.m1_addr(addr[1]),
		.m1_wdata(wdata[1]),
		.*
	);

	soc_checker check_i (.*);

	controller_model #(
		.BUTTONS(PAD0_BUTTONS)
	) pad0_i (
		.pad_clk(pad_clk),
		.pad_latch(pad_latch),
		.data(pad_data[0])
	);

	controller_model #(
		.BUTTONS(PAD1_BUTTONS)
	) pad1_i (
		.pad_clk(pad_clk),
		.pad_latch(pad_latch),
		.data(pad_data[1])
	);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	always @(posedge pad_latch)
		latch_count <= latch_count + 1;

	always @(posedge clk_50mhz) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT) begin
			$display("Timeout after %0d cycles, test %0d is still waiting for its ack",
				LIMIT, cur_test);
			$display("Result: FAILED");
			$finish;
		end
	end

	// One full four-phase cycle on the entry's master
	task automatic run_entry(input int idx);
		entry_t e;
		logic   m;
		e = tbl[idx];
		m = e.master;
		cur_test = idx;
		exp_rdata[m] = e.rdata;
		exp_err[m] = e.err;
		exp_rot[m] = e.rot;
		exp_cnt[m] = e.cnt;
		test_id[m] = 8'(idx);
		we[m] = e.we;
		addr[m] = e.addr;
		wdata[m] = e.wdata;
		req[m] = 1'b1;
		@(posedge clk_50mhz);
		while (!ack[m])
			@(posedge clk_50mhz);
		#1;
		req[m] = 1'b0;
		@(posedge clk_50mhz);
		while (ack[m])
			@(posedge clk_50mhz);
		#1;
	endtask

	initial begin
		// master, we, addr, wdata, rdata, err, rot, counter read, paired with next
		tbl = '{
			'{1'b0, 1'b1, 16'h0000, 32'hdead_beef, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b1, 1'b1, 16'h0004, 32'h1234_5678, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b0, 16'h0500, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1, 1'b0},
			'{1'b1, 1'b0, 16'h0000, 32'h0000_0000, 32'hdead_beef, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b0, 16'h0004, 32'h0000_0000, 32'h1234_5678, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b1, 16'h0400, 32'h0000_0001, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 1'b0},
			'{1'b1, 1'b0, 16'h0400, 32'h0000_0000, 32'h0000_0001, 1'b0, 1'b1, 1'b0, 1'b0},
			'{1'b1, 1'b1, 16'h0404, 32'hcafe_0002, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 1'b0},
			'{1'b0, 1'b1, 16'h0408, 32'h0bad_0003, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 1'b0},
			'{1'b1, 1'b1, 16'h040c, 32'h55aa_55aa, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 1'b0},
			'{1'b0, 1'b0, 16'h0404, 32'h0000_0000, 32'hcafe_0002, 1'b0, 1'b1, 1'b0, 1'b0},
			'{1'b1, 1'b0, 16'h0408, 32'h0000_0000, 32'h0bad_0003, 1'b0, 1'b1, 1'b0, 1'b0},
			'{1'b0, 1'b0, 16'h040c, 32'h0000_0000, 32'h55aa_55aa, 1'b0, 1'b1, 1'b0, 1'b0},
			'{1'b1, 1'b1, 16'h0400, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b0, 16'h0400, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b1, 1'b0, 16'h0500, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1, 1'b0},
			'{1'b0, 1'b0, 16'h0600, 32'h0000_0000, PAD_WORD,      1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b1, 16'h0800, 32'hffff_ffff, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0},
			'{1'b1, 1'b1, 16'h0410, 32'hffff_ffff, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b0, 16'h0504, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0},
			'{1'b1, 1'b0, 16'h0000, 32'h0000_0000, 32'hdead_beef, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b0, 16'h040c, 32'h0000_0000, 32'h55aa_55aa, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b1, 16'h0010, 32'ha1a1_a1a1, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b1},
			'{1'b1, 1'b1, 16'h0014, 32'hb2b2_b2b2, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b0, 1'b0, 16'h0014, 32'h0000_0000, 32'hb2b2_b2b2, 1'b0, 1'b0, 1'b0, 1'b1},
			'{1'b1, 1'b0, 16'h0010, 32'h0000_0000, 32'ha1a1_a1a1, 1'b0, 1'b0, 1'b0, 1'b0},
			'{1'b1, 1'b0, 16'h0500, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1, 1'b0},
			'{1'b1, 1'b0, 16'h0600, 32'h0000_0000, PAD_WORD,      1'b0, 1'b0, 1'b0, 1'b1},
			'{1'b0, 1'b0, 16'h0004, 32'h0000_0000, 32'h1234_5678, 1'b0, 1'b0, 1'b0, 1'b0}
		};
		resetn = 1'b0;
		req = 2'b00;
		we = 2'b00;
		addr[0] = '0;
		addr[1] = '0;
		wdata[0] = '0;
		wdata[1] = '0;
		exp_rdata = '0;
		exp_err = 2'b00;
		exp_rot = 2'b00;
		exp_cnt = 2'b00;
		test_id = '0;
		pair_on = 1'b0;
		exp_first = 1'b0;
		last_m = 1'b0;
		repeat (5) @(posedge clk_50mhz);
		#1;
		resetn = 1'b1;

		// A second latch means one whole poll has finished
		while (latch_count < 2)
			@(posedge clk_50mhz);
		#1;

		i = 0;
		while (i < N_TESTS) begin
			if (tbl[i].pair) begin
				// Round robin hands a tie to the master not served last
				exp_first = ~last_m;
				pair_on = 1'b1;
				fork
					run_entry(i);
					run_entry(i + 1);
				join
				pair_on = 1'b0;
				last_m = ~exp_first;
				i = i + 2;
			end else begin
				run_entry(i);
				last_m = tbl[i].master;
				i = i + 1;
			end
		end

		repeat (2) @(posedge clk_50mhz);
		$display("Tests: %0d run, %0d passed, %0d failed", checked, checked - failed, failed);
		if (failed == 0 && checked == N_TESTS) begin
			$display("Result: PASSED");
		end else begin
			if (checked != N_TESTS)
				$display("Only %0d of %0d tests saw an ack", checked, N_TESTS);
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// Serial game controller: reloads its buttons on latch, shifts on each clock pulse
module controller_model #(
	parameter logic [soc_pkg::PAD_BITS-1:0] BUTTONS = '0
) (
	input  logic pad_clk,
	input  logic pad_latch,
	output logic data
);

	logic [soc_pkg::PAD_BITS-1:0] shreg = '0;

	// Pressed button pulls the line low
	assign data = ~shreg[0];

	always @(posedge pad_latch or posedge pad_clk) begin
		#1;
		if (pad_latch)
			shreg = BUTTONS;
		else
			shreg = shreg >> 1;
	end

endmodule

//--- all.f
src/soc_pkg.sv
src/bus_fabric.sv
src/scratch_ram.sv
src/config_regs.sv
src/system_counter.sv
src/gamepad_reader.sv
src/soc_top.sv
testbench/soc_sva.sv
testbench/soc_checker.sv
testbench/soc_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the SoC testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module soc_tb -f all.f
out=$(./obj_dir/Vsoc_tb 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "Result: PASSED"
